// ==== design/fifo_cfg_pkg.sv ====
//////////////////////////////
// Storage geometry and payload word of the async FIFO
// Shared by the RTL and the testbench through scoped names
//////////////////////////////

`default_nettype none

package fifo_cfg_pkg;

	// Address bits into the storage array
	// Storage holds two to this power entries
	localparam int LGFIFO = 3;

	// Bits per stored word
	localparam int WIDTH = 16;

	// Entries in the storage array
	// The output register adds one more word of capacity
	localparam int DEPTH = 1 << LGFIFO;

	// One payload word
	typedef logic [WIDTH-1:0] data_t;

	// Index into the storage array
	// Drops the wrap bit of a pointer
	typedef logic [LGFIFO-1:0] addr_t;

endpackage

`default_nettype wire

// ==== design/cdc_pkg.sv ====
//////////////////////////////
// Clock crossing definitions for the FIFO pointers
// Synchronizer depth, pointer type and Gray encoding
//////////////////////////////

`default_nettype none

package cdc_pkg;

	// Flops per crossing, two at minimum
	localparam int NFF = 2;

	// Binary or Gray pointer
	// Top bit is the wrap bit, the rest addresses storage
	typedef logic [fifo_cfg_pkg::LGFIFO:0] ptr_t;

	//////////////////////////////
	// Gray conversion
	//////////////////////////////

	// Adjacent codes differ in a single bit
	// so a pointer sampled mid-change is off by one at most
	function automatic ptr_t bin_to_gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

endpackage

`default_nettype wire

// ==== design/gray_sync.sv ====
//////////////////////////////
// Multi-flop synchronizer for one Gray pointer
// Clock and reset come from the receiving domain
//////////////////////////////

`default_nettype none

module gray_sync
(
	// Receiving clock domain
	input  wire                 gbl_clk,
	input  wire                 i_rd_reset_n,

	// Pointer from the far domain
	input  wire  cdc_pkg::ptr_t i_gray,

	// Same pointer NFF edges later
	output cdc_pkg::ptr_t       o_gray
);

	// Shift chain with stage 0 as the metastable one
	cdc_pkg::ptr_t [cdc_pkg::NFF-1:0] sync_q;

	// Shift the pointer one stage per edge
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			sync_q <= '0;
		else
			sync_q <= {sync_q[cdc_pkg::NFF-2:0], i_gray};
	end

	// Last stage is safe to use in this domain
	assign o_gray = sync_q[cdc_pkg::NFF-1];

endmodule

`default_nettype wire

// ==== design/afifo_mem.sv ====
//////////////////////////////
// Dual-port storage of the async FIFO
// Written on the write clock and read by address with no clock
//////////////////////////////

`default_nettype none

module afifo_mem
(
	// Write port in the write clock domain
	input  wire                       i_wr_clk,
	input  wire                       i_wr_en,
	input  wire  fifo_cfg_pkg::addr_t i_wr_addr,
	input  wire  fifo_cfg_pkg::data_t i_wr_data,

	// Read port addressed from the read domain
	input  wire  fifo_cfg_pkg::addr_t i_rd_addr,
	output fifo_cfg_pkg::data_t       o_rd_data
);

	// Word array
	// Contents after power-up are don't care
	fifo_cfg_pkg::data_t mem [fifo_cfg_pkg::DEPTH];

	// Write enable already carries the not-full check
	always_ff @(posedge i_wr_clk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// Combinational read
	// The read controller registers this word
	assign o_rd_data = mem[i_rd_addr];

endmodule

`default_nettype wire

// ==== design/afifo_wr_ctrl.sv ====
//////////////////////////////
// Write side controller of the async FIFO
// Keeps the write pointers, drives storage and raises full
//////////////////////////////

`default_nettype none

module afifo_wr_ctrl
(
	// Write clock domain
	input  wire                       i_wr_clk,
	input  wire                       i_wr_reset_n,

	// Write request from the producer
	input  wire                       i_wr,

	// Read Gray pointer after synchronization
	input  wire  cdc_pkg::ptr_t       i_rgray_sync,

	// No room for another word
	output logic                      o_wr_full,

	// Storage write port
	output logic                      o_mem_wr_en,
	output fifo_cfg_pkg::addr_t       o_mem_wr_addr,

	// Own Gray pointer toward the read domain
	output cdc_pkg::ptr_t             o_wgray
);

	// Binary write pointer and its Gray copy
	cdc_pkg::ptr_t wr_bin;
	cdc_pkg::ptr_t wr_bin_next;
	cdc_pkg::ptr_t wr_gray;

	// Word accepted this edge
	logic wr_accept;

	//////////////////////////////
	// Pointer update
	//////////////////////////////

	assign wr_accept   = i_wr && !o_wr_full;
	assign wr_bin_next = wr_bin + cdc_pkg::ptr_t'(1);

	// Gray copy is registered so the crossing sees clean edges
	always_ff @(posedge i_wr_clk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wr_bin  <= '0;
			wr_gray <= '0;
		end
		else if (wr_accept)
		begin
			wr_bin  <= wr_bin_next;
			wr_gray <= cdc_pkg::bin_to_gray(wr_bin_next);
		end
	end

	//////////////////////////////
	// Full flag
	//////////////////////////////

	// Full when the writer is one lap ahead
	// In Gray code that flips the top two bits
	assign o_wr_full = (i_rgray_sync ==
		{~wr_gray[fifo_cfg_pkg::LGFIFO -: 2], wr_gray[fifo_cfg_pkg::LGFIFO-2:0]});

	// Storage port
	assign o_mem_wr_en   = wr_accept;
	assign o_mem_wr_addr = wr_bin[fifo_cfg_pkg::LGFIFO-1:0];

	// Pointer toward the read side
	assign o_wgray = wr_gray;

endmodule

`default_nettype wire

// ==== design/afifo_rd_ctrl.sv ====
//////////////////////////////
// Read side controller of the async FIFO
// Read pointers, empty detection and the output register
//////////////////////////////

`default_nettype none

module afifo_rd_ctrl
(
	// Read clock domain
	input  wire                       gbl_clk,
	input  wire                       i_rd_reset_n,

	// Read request from the consumer
	input  wire                       i_rd,

	// Write Gray pointer after synchronization
	input  wire  cdc_pkg::ptr_t       i_wgray_sync,

	// Storage read port
	input  wire  fifo_cfg_pkg::data_t i_mem_data,
	output fifo_cfg_pkg::addr_t       o_mem_rd_addr,

	// Own Gray pointer toward the write domain
	output cdc_pkg::ptr_t             o_rgray,

	// Output stage toward the consumer
	output fifo_cfg_pkg::data_t       o_rd_data,
	output logic                      o_rd_empty
);

	// Binary read pointer and its Gray copy
	cdc_pkg::ptr_t rd_bin;
	cdc_pkg::ptr_t rd_bin_next;
	cdc_pkg::ptr_t rd_gray;

	// Storage holds nothing unread
	logic lcl_empty;

	// Output register takes a new value
	logic stage_load;

	// A storage word moves into the output register
	logic rd_take;

	//////////////////////////////
	// Empty detection
	//////////////////////////////

	// Pointers equal in every bit means nothing to read
	assign lcl_empty = (i_wgray_sync == rd_gray);

	// Load when the stage is empty or its word is consumed
	assign stage_load = o_rd_empty || i_rd;
	assign rd_take    = stage_load && !lcl_empty;

	//////////////////////////////
	// Pointer update
	//////////////////////////////

	assign rd_bin_next = rd_bin + cdc_pkg::ptr_t'(1);

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rd_bin  <= '0;
			rd_gray <= '0;
		end
		else if (rd_take)
		begin
			rd_bin  <= rd_bin_next;
			rd_gray <= cdc_pkg::bin_to_gray(rd_bin_next);
		end
	end

	//////////////////////////////
	// Output stage
	//////////////////////////////

	// Empty follows storage whenever the stage reloads
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			o_rd_empty <= 1'b1;
		else if (stage_load)
			o_rd_empty <= lcl_empty;
	end

	// Payload register held while the consumer stalls
	always_ff @(posedge gbl_clk)
	begin
		if (stage_load)
			o_rd_data <= i_mem_data;
	end

	assign o_mem_rd_addr = rd_bin[fifo_cfg_pkg::LGFIFO-1:0];
	assign o_rgray       = rd_gray;

endmodule

`default_nettype wire

// ==== design/afifo_top.sv ====
//////////////////////////////
// Asynchronous FIFO top level
// Writes on i_wr_clk, reads on gbl_clk
//////////////////////////////

`default_nettype none

module afifo_top
(
	// Write domain
	input  wire                       i_wr_clk,
	input  wire                       i_wr_reset_n,
	input  wire                       i_wr,
	input  wire  fifo_cfg_pkg::data_t i_wr_data,
	output logic                      o_wr_full,

	// Read domain
	input  wire                       gbl_clk,
	input  wire                       i_rd_reset_n,
	input  wire                       i_rd,
	output fifo_cfg_pkg::data_t       o_rd_data,
	output logic                      o_rd_empty
);

	// Storage ports
	logic                mem_wr_en;
	fifo_cfg_pkg::addr_t mem_wr_addr;
	fifo_cfg_pkg::addr_t mem_rd_addr;
	fifo_cfg_pkg::data_t mem_rd_data;

	// Gray pointers at the source
	cdc_pkg::ptr_t wgray;
	cdc_pkg::ptr_t rgray;

	// Gray pointers after the crossing
	cdc_pkg::ptr_t wgray_sync;
	cdc_pkg::ptr_t rgray_sync;

	//////////////////////////////
	// Write side
	//////////////////////////////

	afifo_wr_ctrl u_wr_ctrl (
		.i_wr_clk      (i_wr_clk),
		.i_wr_reset_n  (i_wr_reset_n),
		.i_wr          (i_wr),
		.i_rgray_sync  (rgray_sync),
		.o_wr_full     (o_wr_full),
		.o_mem_wr_en   (mem_wr_en),
		.o_mem_wr_addr (mem_wr_addr),
		.o_wgray       (wgray)
	);

	// Write data goes straight into storage
	afifo_mem u_mem (
		.i_wr_clk  (i_wr_clk),
		.i_wr_en   (mem_wr_en),
		.i_wr_addr (mem_wr_addr),
		.i_wr_data (i_wr_data),
		.i_rd_addr (mem_rd_addr),
		.o_rd_data (mem_rd_data)
	);

	//////////////////////////////
	// Crossings
	//////////////////////////////

	// Write pointer into the read domain
	gray_sync u_wgray_sync (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_gray       (wgray),
		.o_gray       (wgray_sync)
	);

	// Read pointer into the write domain, on its clock and reset
	gray_sync u_rgray_sync (
		.gbl_clk      (i_wr_clk),
		.i_rd_reset_n (i_wr_reset_n),
		.i_gray       (rgray),
		.o_gray       (rgray_sync)
	);

	// Read side
	afifo_rd_ctrl u_rd_ctrl (
		.gbl_clk       (gbl_clk),
		.i_rd_reset_n  (i_rd_reset_n),
		.i_rd          (i_rd),
		.i_wgray_sync  (wgray_sync),
		.i_mem_data    (mem_rd_data),
		.o_mem_rd_addr (mem_rd_addr),
		.o_rgray       (rgray),
		.o_rd_data     (o_rd_data),
		.o_rd_empty    (o_rd_empty)
	);

endmodule

`default_nettype wire

// ==== dv/afifo_checker.sv ====
//////////////////////////////
// Scoreboard for the async FIFO testbench
// Logs accepted writes and checks every consumed word in order
//////////////////////////////

`default_nettype none

module afifo_checker
(
	// Write side, as seen at the DUT ports
	input  wire                       i_wr_clk,
	input  wire                       i_wr_reset_n,
	input  wire                       i_wr,
	input  wire  fifo_cfg_pkg::data_t i_wr_data,
	input  wire                       i_wr_full,

	// Read side, as seen at the DUT ports
	input  wire                       gbl_clk,
	input  wire                       i_rd_reset_n,
	input  wire                       i_rd,
	input  wire  fifo_cfg_pkg::data_t i_rd_data,
	input  wire                       i_rd_empty,

	// Running counts for the testbench top
	output int                        o_written,
	output int                        o_consumed,
	output int                        o_checks,
	output int                        o_errors
);

	// Reference queue, every accepted word in write order
	// Head is the entry at index o_consumed
	fifo_cfg_pkg::data_t wr_log [$];

	// Output word at the last edge, and whether it had to hold
	fifo_cfg_pkg::data_t last_data;
	logic                last_hold;

	// Values sampled at the edge are the ones the DUT used
	always @(posedge i_wr_clk)
	begin
		if (i_wr_reset_n && i_wr === 1'b1 && i_wr_full === 1'b0)
		begin
			wr_log.push_back(i_wr_data);
			o_written = wr_log.size();
		end
	end

	always @(posedge gbl_clk)
	begin
		if (!i_rd_reset_n)
			last_hold = 1'b0;
		else
		begin
			// Stalled output register must keep its word
			if (last_hold)
			begin
				o_checks++;
				if (i_rd_data !== last_data)
				begin
					o_errors++;
					$display("ERROR t=%0t o_rd_data expected %h actual %h",
						$time, last_data, i_rd_data);
				end
			end
			// Consuming read, compare with the oldest unread write
			if (i_rd === 1'b1 && i_rd_empty === 1'b0)
			begin
				if (o_consumed >= wr_log.size())
				begin
					o_errors++;
					$display("At t=%0t the FIFO delivered a word that was never written", $time);
				end
				else
				begin
					o_checks++;
					if (i_rd_data !== wr_log[o_consumed])
					begin
						o_errors++;
						$display("ERROR t=%0t o_rd_data expected %h actual %h",
							$time, wr_log[o_consumed], i_rd_data);
					end
					o_consumed++;
				end
			end
			last_hold = (i_rd_empty === 1'b0) && (i_rd === 1'b0);
			last_data = i_rd_data;
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_afifo.sv ====
//////////////////////////////
// Testbench for the async FIFO
// Random two-clock traffic, then capacity, hold and drain tests
//////////////////////////////

`default_nettype none

module tb_afifo;

	// Phase lengths in cycles of the driving clock
	localparam int RAND_CYCLES   = 400;
	localparam int FILL_CYCLES   = 40;
	localparam int IGNORE_CYCLES = 20;
	localparam int HOLD_CYCLES   = 20;
	localparam int STAY_CYCLES   = 10;
	localparam int DRIVE_DELAY   = 2;

	// Run limit in gbl_clk cycles
	localparam int TIMEOUT_CYCLES =
		4 * (RAND_CYCLES + FILL_CYCLES + IGNORE_CYCLES + HOLD_CYCLES + STAY_CYCLES) + 200;

	// DUT ports
	logic                gbl_clk;
	logic                i_wr_clk;
	logic                i_rd_reset_n;
	logic                i_wr_reset_n;
	logic                i_wr;
	logic                i_rd;
	fifo_cfg_pkg::data_t i_wr_data;
	fifo_cfg_pkg::data_t o_rd_data;
	logic                o_wr_full;
	logic                o_rd_empty;

	// Scoreboard counts
	int written;
	int consumed;
	int chk_checks;
	int chk_errors;

	// Own checks and bookkeeping
	int          tb_checks;
	int          tb_errors;
	int          errors_before;
	int          tests_done;
	int          cycle_count;
	logic [31:0] lfsr_state;

	//////////////////////////////
	// Clocks, DUT and scoreboard
	//////////////////////////////

	initial
	begin
		gbl_clk = 1'b0;
		forever #10 gbl_clk = ~gbl_clk;
	end

	// Rising edges at 7+14k never meet those at 10+20m
	initial
	begin
		i_wr_clk = 1'b0;
		forever #7 i_wr_clk = ~i_wr_clk;
	end

	afifo_top dut_i (
		.i_wr_clk     (i_wr_clk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.o_wr_full    (o_wr_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty)
	);

	afifo_checker chk_i (
		.i_wr_clk     (i_wr_clk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.i_wr_full    (o_wr_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.i_rd_data    (o_rd_data),
		.i_rd_empty   (o_rd_empty),
		.o_written    (written),
		.o_consumed   (consumed),
		.o_checks     (chk_checks),
		.o_errors     (chk_errors)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int k = 0; k < n; k++)
		begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			else
				lfsr_state = lfsr_state >> 1;
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	function automatic int error_total();
		return tb_errors + chk_errors;
	endfunction

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		tb_errors++;
		$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("Test %0d %s: %0d errors", tests_done, name, error_total() - errors_before);
		errors_before = error_total();
	endtask

	// Writer is fast in even segments of 100 cycles, slow in odd ones
	task automatic random_writes();
		for (int n = 0; n < RAND_CYCLES; n++)
		begin
			@(posedge i_wr_clk);
			#DRIVE_DELAY;
			i_wr = ((n / 100) % 2 == 0) ? (take_bits(2) != 0) : (take_bits(2) == 0);
			i_wr_data = fifo_cfg_pkg::data_t'(take_bits(fifo_cfg_pkg::WIDTH));
		end
		@(posedge i_wr_clk);
		#DRIVE_DELAY;
		i_wr = 1'b0;
	endtask

	// Reader rates are the mirror image, so both full and empty occur
	task automatic random_reads();
		for (int n = 0; n < RAND_CYCLES; n++)
		begin
			@(posedge gbl_clk);
			#DRIVE_DELAY;
			i_rd = ((n / 100) % 2 == 0) ? (take_bits(2) == 0) : (take_bits(2) != 0);
		end
		@(posedge gbl_clk);
		#DRIVE_DELAY;
		i_rd = 1'b0;
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int                  written_before;
		fifo_cfg_pkg::data_t held_data;
		i_rd_reset_n  = 1'b0;
		i_wr_reset_n  = 1'b0;
		i_wr          = 1'b0;
		i_rd          = 1'b0;
		i_wr_data     = '0;
		lfsr_state    = 32'hd598c8aa;
		tb_checks     = 0;
		tb_errors     = 0;
		errors_before = 0;
		tests_done    = 0;

		// Both resets held for 10 gbl_clk cycles
		repeat (10) @(posedge gbl_clk);
		#DRIVE_DELAY;
		i_rd_reset_n = 1'b1;
		@(posedge i_wr_clk);
		#DRIVE_DELAY;
		i_wr_reset_n = 1'b1;
		@(posedge gbl_clk);
		#DRIVE_DELAY;

		// Reset state
		tb_checks += 2;
		if (o_rd_empty !== 1'b1)
			value_error("o_rd_empty", 32'd1, 32'(o_rd_empty));
		if (o_wr_full !== 1'b0)
			value_error("o_wr_full", 32'd0, 32'(o_wr_full));
		finish_test("reset state");

		// Ordering under random rates, the scoreboard compares
		fork
			random_writes();
			random_reads();
		join
		finish_test("random ordering");

		// Reader stalled, writer saturating
		for (int n = 0; n < FILL_CYCLES; n++)
		begin
			@(posedge i_wr_clk);
			#DRIVE_DELAY;
			i_wr      = 1'b1;
			i_wr_data = fifo_cfg_pkg::data_t'(take_bits(fifo_cfg_pkg::WIDTH));
		end
		tb_checks += 2;
		if (written - consumed != fifo_cfg_pkg::DEPTH + 1)
			value_error("fill level", 32'(fifo_cfg_pkg::DEPTH + 1), 32'(written - consumed));
		if (o_wr_full !== 1'b1)
			value_error("o_wr_full", 32'd1, 32'(o_wr_full));
		finish_test("capacity");

		// Marker words offered while full, none may be taken
		written_before = written;
		for (int n = 0; n < IGNORE_CYCLES; n++)
		begin
			@(posedge i_wr_clk);
			#DRIVE_DELAY;
			tb_checks++;
			if (o_wr_full !== 1'b1)
				value_error("o_wr_full", 32'd1, 32'(o_wr_full));
			i_wr_data = fifo_cfg_pkg::data_t'(16'hbad0 + n);
		end
		@(posedge i_wr_clk);
		#DRIVE_DELAY;
		i_wr = 1'b0;
		tb_checks++;
		if (written != written_before)
			value_error("accepted writes", 32'(written_before), 32'(written));
		finish_test("ignored writes");

		// Output word frozen while the reader stalls
		@(posedge gbl_clk);
		#DRIVE_DELAY;
		held_data = o_rd_data;
		tb_checks++;
		if (o_rd_empty !== 1'b0)
			value_error("o_rd_empty", 32'd0, 32'(o_rd_empty));
		repeat (HOLD_CYCLES)
		begin
			@(posedge gbl_clk);
			#DRIVE_DELAY;
			tb_checks++;
			if (o_rd_data !== held_data)
				value_error("o_rd_data", 32'(held_data), 32'(o_rd_data));
		end
		finish_test("hold under back-pressure");

		// Read until the DUT and the model are both empty
		i_rd = 1'b1;
		while (!(o_rd_empty === 1'b1 && written == consumed))
		begin
			@(posedge gbl_clk);
			#DRIVE_DELAY;
		end
		i_rd = 1'b0;
		repeat (STAY_CYCLES)
		begin
			@(posedge gbl_clk);
			#DRIVE_DELAY;
			tb_checks++;
			if (o_rd_empty !== 1'b1 || written != consumed)
			begin
				tb_errors++;
				$display("At t=%0t the FIFO did not stay empty after the drain", $time);
			end
		end
		finish_test("drain");

		$display("Tests: %0d, checks: %0d, errors: %0d",
			tests_done, tb_checks + chk_checks, error_total());
		if (error_total() == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Run limit
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge gbl_clk);
			cycle_count++;
		end
		$display("Timeout, the run did not end within %0d gbl_clk cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
// Packages first, then RTL bottom up, then the testbench
design/fifo_cfg_pkg.sv
design/cdc_pkg.sv
design/gray_sync.sv
design/afifo_mem.sv
design/afifo_wr_ctrl.sv
design/afifo_rd_ctrl.sv
design/afifo_top.sv
dv/afifo_checker.sv
dv/tb_afifo.sv

// ==== Makefile ====
# Verilator build and run of the async FIFO testbench

SRCS := $(shell grep '\.sv$$' filelist.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_afifo: filelist.f $(SRCS)
	verilator --binary --timing --top-module tb_afifo -f filelist.f

# Fails unless the pass line shows up in the output
run: obj_dir/Vtb_afifo
	@out="$$(./obj_dir/Vtb_afifo)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir
